// ==== invsqrt_pkg.sv ====
// Widths, typedefs and constants shared by the inverse square root accelerator.
// Also the AXI4-Lite address map and the write-channel state encoding.
`default_nettype none

package invsqrt_pkg;

    localparam int ADDR_W       = 8;
    localparam int FRAC_W       = 56;   // One integer bit, FRAC_W-1 fraction bits.
    localparam int SEED_ABITS   = 7;    // Exponent low bit and six fraction bits.
    localparam int LANE_STRIDE  = 16;   // Bytes of address space per lane.
    localparam int OFF_W        = $clog2(LANE_STRIDE);
    localparam int LANE_LATENCY = 5;    // Launch to result_valid, in cycles.

    typedef logic [63:0]       fp64_t;
    typedef logic [31:0]       word_t;
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [FRAC_W-1:0] seed_t;
    typedef logic [10:0]       exp_t;

    ////////////////////
    // Address map.
    localparam addr_t             STATUS_ADDR = 8'hF0;
    localparam logic [OFF_W-1:0]  OFF_OP_LO   = 4'h0;
    localparam logic [OFF_W-1:0]  OFF_OP_HI   = 4'h4;   // Launches the lane.
    localparam logic [OFF_W-1:0]  OFF_RES_LO  = 4'h8;
    localparam logic [OFF_W-1:0]  OFF_RES_HI  = 4'hC;   // Clears the done flag.

    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    localparam fp64_t FP_QNAN     = 64'h7FF8_0000_0000_0001;
    localparam fp64_t FP_POS_INF  = 64'h7FF0_0000_0000_0000;
    localparam fp64_t FP_POS_ZERO = 64'h0000_0000_0000_0000;

    typedef enum logic {WR_IDLE, WR_RESP} wr_state_t;

endpackage

`default_nettype wire

// ==== invsqrt_seed_rom.sv ====
// Registered seed table for the inverse square root lanes.
// Entries are computed at elaboration with real arithmetic.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_seed_rom (
    input  logic                                 clk,
    input  logic [invsqrt_pkg::SEED_ABITS-1:0]   addr,
    output invsqrt_pkg::seed_t                   seed
);

    localparam int DEPTH = 2 ** invsqrt_pkg::SEED_ABITS;
    localparam int HALF  = DEPTH / 2;   // Entries per exponent parity.

    // Bit 6 of the index is the exponent low bit. When it is clear the
    // unbiased exponent is odd and the operand is taken as m/2.
    function automatic invsqrt_pkg::seed_t seed_value(input int a);
        real m;
        real v;
        real y;
        int  q;
        m = 1.0 + (real'(a % HALF) + 0.5) / real'(HALF);   // Interval midpoint.
        v = (a >= HALF) ? m : m / 2.0;
        y = 1.0;
        for (int k = 0; k < 40; k++) begin
            y = y * (1.5 - 0.5 * v * y * y);
        end
        q = $rtoi(y * 1073741824.0);                       // 30 fraction bits.
        return invsqrt_pkg::seed_t'(q) << (invsqrt_pkg::FRAC_W - 31);
    endfunction

    invsqrt_pkg::seed_t rom_w [DEPTH];

    for (genvar i = 0; i < DEPTH; i++) begin : g_entry
        localparam invsqrt_pkg::seed_t ENTRY = seed_value(i);
        assign rom_w[i] = ENTRY;
    end

    always_ff @(posedge clk) begin
        seed <= rom_w[addr];
    end

endmodule

`default_nettype wire

// ==== invsqrt_nr_stage.sv ====
// One registered Newton-Raphson step for 1/sqrt in fixed point.
// The special-case code and output exponent travel alongside.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_nr_stage (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                in_valid,
    input  invsqrt_pkg::seed_t  y_in,
    input  invsqrt_pkg::seed_t  half_x_in,
    input  logic [63:0]         fields_in,
    output logic                out_valid,
    output invsqrt_pkg::seed_t  y_out,
    output invsqrt_pkg::seed_t  half_x_out,
    output logic [63:0]         fields_out
);

    localparam int FW = invsqrt_pkg::FRAC_W;
    localparam invsqrt_pkg::seed_t THREE_HALVES = invsqrt_pkg::seed_t'(3) << (FW - 2);

    logic [2*FW-1:0]    sq_full;
    logic [2*FW-1:0]    hxy_full;
    logic [2*FW-1:0]    prod_full;
    invsqrt_pkg::seed_t y_sq;
    invsqrt_pkg::seed_t hxy;
    invsqrt_pkg::seed_t corr;

    // y * (1.5 - x/2 * y^2), every product truncated back to FW bits.
    always_comb begin
        sq_full   = y_in * y_in;
        y_sq      = sq_full[2*FW-2 -: FW];      // Below 2, top bit always clear.
        hxy_full  = half_x_in * y_sq;
        hxy       = hxy_full[2*FW-2 -: FW];
        corr      = THREE_HALVES - hxy;         // Close to one once converging.
        prod_full = y_in * corr;
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        y_out      <= prod_full[2*FW-2 -: FW];
        half_x_out <= half_x_in;
        fields_out <= fields_in;
    end

endmodule

`default_nettype wire

// ==== invsqrt_lane.sv ====
// Five-cycle inverse square root lane: classify and seed lookup,
// three refinement steps, then normalize, round and pack the result.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_lane (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                launch,
    input  invsqrt_pkg::fp64_t  operand,
    output logic                result_valid,
    output invsqrt_pkg::fp64_t  result
);

    localparam int          FW        = invsqrt_pkg::FRAC_W;
    localparam int          NR_STAGES = 3;
    localparam logic [11:0] EXP_3BIAS = 12'd3069;  // Three times the bias.

    // Special-case codes.
    localparam logic [1:0] CODE_NORMAL = 2'd0;
    localparam logic [1:0] CODE_QNAN   = 2'd1;
    localparam logic [1:0] CODE_INF    = 2'd2;
    localparam logic [1:0] CODE_ZERO   = 2'd3;

    logic               sign_in;
    invsqrt_pkg::exp_t  exp_in;
    logic [51:0]        frac_in;
    logic [1:0]         code_c;
    logic [11:0]        exp_diff;
    invsqrt_pkg::seed_t half_x_c;
    logic               v1;
    invsqrt_pkg::seed_t seed1;
    invsqrt_pkg::seed_t hx1;
    logic [63:0]        fld1;

    logic               v_q   [NR_STAGES+1];
    invsqrt_pkg::seed_t y_q   [NR_STAGES+1];
    invsqrt_pkg::seed_t hx_q  [NR_STAGES+1];
    logic [63:0]        fld_q [NR_STAGES+1];

    ////////////////////
    // Stage 1.
    assign sign_in  = operand[63];
    assign exp_in   = operand[62:52];
    assign frac_in  = operand[51:0];
    assign exp_diff = EXP_3BIAS - {1'b0, exp_in};
    // Odd biased exponent means even unbiased, so x/2 = m/2, otherwise m/4.
    assign half_x_c = exp_in[0] ? {2'b01, frac_in, 2'b00} : {3'b001, frac_in, 1'b0};

    always_comb begin
        if (exp_in == 11'h7FF && frac_in != '0) begin
            code_c = CODE_QNAN;
        end else if (exp_in == '0) begin
            code_c = CODE_INF;      // Zero, or a subnormal flushed to zero.
        end else if (sign_in) begin
            code_c = CODE_QNAN;
        end else if (exp_in == 11'h7FF) begin
            code_c = CODE_ZERO;
        end else begin
            code_c = CODE_NORMAL;
        end
    end

    invsqrt_seed_rom u_rom (
        .clk  (clk),
        .addr ({exp_in[0], frac_in[51:46]}),
        .seed (seed1)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            v1 <= 1'b0;
        end else begin
            v1 <= launch;
        end
    end

    always_ff @(posedge clk) begin
        hx1  <= half_x_c;
        fld1 <= {51'd0, code_c, exp_diff[11:1]};    // Output exponent is diff/2.
    end

    ////////////////////
    // Refinement chain.
    assign v_q[0]   = v1;
    assign y_q[0]   = seed1;
    assign hx_q[0]  = hx1;
    assign fld_q[0] = fld1;

    for (genvar k = 0; k < NR_STAGES; k++) begin : g_nr
        invsqrt_nr_stage u_nr (
            .clk        (clk),
            .rst_n      (rst_n),
            .in_valid   (v_q[k]),
            .y_in       (y_q[k]),
            .half_x_in  (hx_q[k]),
            .fields_in  (fld_q[k]),
            .out_valid  (v_q[k+1]),
            .y_out      (y_q[k+1]),
            .half_x_out (hx_q[k+1]),
            .fields_out (fld_q[k+1])
        );
    end

    ////////////////////
    // Pack.
    invsqrt_pkg::seed_t y_f;
    invsqrt_pkg::seed_t norm;
    invsqrt_pkg::exp_t  exp_f;
    invsqrt_pkg::exp_t  exp_pk;
    logic [1:0]         code_f;
    logic               below;
    logic [53:0]        rsum;
    invsqrt_pkg::fp64_t pack_c;

    assign y_f    = y_q[NR_STAGES];
    assign code_f = fld_q[NR_STAGES][12:11];
    assign exp_f  = fld_q[NR_STAGES][10:0];

    always_comb begin
        below  = ~y_f[FW-1];
        norm   = below ? {y_f[FW-2:0], 1'b0} : y_f;
        rsum   = {1'b0, norm[FW-1:FW-53]} + 54'(norm[FW-54]);   // Round half up.
        exp_pk = exp_f - invsqrt_pkg::exp_t'(below) + invsqrt_pkg::exp_t'(rsum[53]);
        case (code_f)
            CODE_QNAN: pack_c = invsqrt_pkg::FP_QNAN;
            CODE_INF:  pack_c = invsqrt_pkg::FP_POS_INF;
            CODE_ZERO: pack_c = invsqrt_pkg::FP_POS_ZERO;
            default:   pack_c = {1'b0, exp_pk, rsum[53] ? 52'd0 : rsum[51:0]};
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            result_valid <= 1'b0;
        end else begin
            result_valid <= v_q[NR_STAGES];
        end
    end

    always_ff @(posedge clk) begin
        result <= pack_c;
    end

endmodule

`default_nettype wire

// ==== invsqrt_dispatch.sv ====
// AXI4-Lite write channel, per-lane operand assembly and lane launch.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_dispatch #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  invsqrt_pkg::addr_t       awaddr,
    input  logic                     awvalid,
    output logic                     awready,
    input  invsqrt_pkg::word_t       wdata,
    input  logic                     wvalid,
    output logic                     wready,
    output logic [1:0]               bresp,
    output logic                     bvalid,
    input  logic                     bready,
    output logic [NUM_LANES-1:0]     launch,
    output logic [NUM_LANES*64-1:0]  operand
);

    localparam int OFF_W  = invsqrt_pkg::OFF_W;
    localparam int LANE_W = invsqrt_pkg::ADDR_W - OFF_W;

    invsqrt_pkg::wr_state_t state;
    invsqrt_pkg::word_t     lo_word [NUM_LANES];
    logic [LANE_W-1:0]      wr_lane;
    logic [OFF_W-1:0]       wr_off;
    logic [NUM_LANES-1:0]   wr_sel;
    logic                   wr_lo;
    logic                   wr_hi;
    logic                   wr_ok;
    logic                   take;

    assign wr_lane = awaddr[invsqrt_pkg::ADDR_W-1:OFF_W];
    assign wr_off  = awaddr[OFF_W-1:0];

    always_comb begin
        for (int i = 0; i < NUM_LANES; i++) begin
            wr_sel[i] = (wr_lane == LANE_W'(i));
        end
    end

    assign wr_lo   = (wr_off == invsqrt_pkg::OFF_OP_LO);
    assign wr_hi   = (wr_off == invsqrt_pkg::OFF_OP_HI);
    assign wr_ok   = (|wr_sel) && (wr_lo || wr_hi);    // Result offsets are read only.
    assign take    = (state == invsqrt_pkg::WR_IDLE) && awvalid && wvalid;
    assign awready = take;
    assign wready  = take;
    assign bvalid  = (state == invsqrt_pkg::WR_RESP);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state  <= invsqrt_pkg::WR_IDLE;
            bresp  <= invsqrt_pkg::RESP_OKAY;
            launch <= '0;
        end else begin
            launch <= (take && wr_hi) ? wr_sel : '0;    // One-cycle pulse.
            case (state)
                invsqrt_pkg::WR_IDLE: begin
                    if (take) begin
                        state <= invsqrt_pkg::WR_RESP;
                        bresp <= wr_ok ? invsqrt_pkg::RESP_OKAY : invsqrt_pkg::RESP_SLVERR;
                    end
                end
                default: begin
                    if (bready) state <= invsqrt_pkg::WR_IDLE;
                end
            endcase
        end
    end

    // Low word waits here until the high word arrives.
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_LANES; i++) begin
            if (take && wr_sel[i] && wr_lo) lo_word[i] <= wdata;
            if (take && wr_sel[i] && wr_hi) operand[i*64 +: 64] <= {wdata, lo_word[i]};
        end
    end

endmodule

`default_nettype wire

// ==== invsqrt_collect.sv ====
// Per-lane result capture and done flags.
// AXI4-Lite read channel with the status word.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_collect #(
    parameter int NUM_LANES = 4
) (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic [NUM_LANES-1:0]     result_valid,
    input  logic [NUM_LANES*64-1:0]  result,
    input  invsqrt_pkg::addr_t       araddr,
    input  logic                     arvalid,
    output logic                     arready,
    output invsqrt_pkg::word_t       rdata,
    output logic [1:0]               rresp,
    output logic                     rvalid,
    input  logic                     rready
);

    localparam int OFF_W  = invsqrt_pkg::OFF_W;
    localparam int LANE_W = invsqrt_pkg::ADDR_W - OFF_W;

    invsqrt_pkg::fp64_t   res_q [NUM_LANES];
    logic [NUM_LANES-1:0] done;
    logic [LANE_W-1:0]    rd_lane;
    logic [OFF_W-1:0]     rd_off;
    logic [NUM_LANES-1:0] rd_clear;
    invsqrt_pkg::word_t   rd_value;
    logic                 rd_take;

    assign rd_lane = araddr[invsqrt_pkg::ADDR_W-1:OFF_W];
    assign rd_off  = araddr[OFF_W-1:0];
    assign rd_take = arvalid && !rvalid;
    assign arready = rd_take;
    assign rresp   = invsqrt_pkg::RESP_OKAY;     // Unmapped reads return zero.

    ////////////////////
    // Read decode.
    always_comb begin
        rd_value = '0;
        rd_clear = '0;
        if (araddr == invsqrt_pkg::STATUS_ADDR) begin
            rd_value = invsqrt_pkg::word_t'(done);
        end
        for (int i = 0; i < NUM_LANES; i++) begin
            if (rd_lane == LANE_W'(i)) begin
                if (rd_off == invsqrt_pkg::OFF_RES_LO) begin
                    rd_value = res_q[i][31:0];
                end
                if (rd_off == invsqrt_pkg::OFF_RES_HI) begin
                    rd_value    = res_q[i][63:32];
                    rd_clear[i] = 1'b1;     // High word read retires the result.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rvalid <= 1'b0;
            done   <= '0;
            for (int i = 0; i < NUM_LANES; i++) begin
                res_q[i] <= '0;
            end
        end else begin
            if (rd_take) begin
                rvalid <= 1'b1;
            end else if (rready) begin
                rvalid <= 1'b0;
            end
            for (int i = 0; i < NUM_LANES; i++) begin
                if (result_valid[i]) begin  // New result wins over a clear.
                    res_q[i] <= result[i*64 +: 64];
                    done[i]  <= 1'b1;
                end else if (rd_take && rd_clear[i]) begin
                    done[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_take) rdata <= rd_value;
    end

endmodule

`default_nettype wire

// ==== invsqrt_top.sv ====
// Accelerator top level: write dispatcher, the lane array and the
// result collector behind one AXI4-Lite slave port.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_top #(
    parameter int NUM_LANES = 4     // 1 to 8.
) (
    input  logic                clk,
    input  logic                rst_n,
    input  invsqrt_pkg::addr_t  awaddr,
    input  logic                awvalid,
    output logic                awready,
    input  invsqrt_pkg::word_t  wdata,
    input  logic                wvalid,
    output logic                wready,
    output logic [1:0]          bresp,
    output logic                bvalid,
    input  logic                bready,
    input  invsqrt_pkg::addr_t  araddr,
    input  logic                arvalid,
    output logic                arready,
    output invsqrt_pkg::word_t  rdata,
    output logic [1:0]          rresp,
    output logic                rvalid,
    input  logic                rready
);

    logic [NUM_LANES-1:0]    launch;
    logic [NUM_LANES*64-1:0] operand;
    logic [NUM_LANES-1:0]    result_valid;
    logic [NUM_LANES*64-1:0] result;

    invsqrt_dispatch #(.NUM_LANES(NUM_LANES)) u_dispatch (
        .clk, .rst_n,
        .awaddr, .awvalid, .awready,
        .wdata, .wvalid, .wready,
        .bresp, .bvalid, .bready,
        .launch, .operand
    );

    for (genvar i = 0; i < NUM_LANES; i++) begin : g_lane
        invsqrt_lane u_lane (
            .clk          (clk),
            .rst_n        (rst_n),
            .launch       (launch[i]),
            .operand      (operand[i*64 +: 64]),
            .result_valid (result_valid[i]),
            .result       (result[i*64 +: 64])
        );
    end

    invsqrt_collect #(.NUM_LANES(NUM_LANES)) u_collect (
        .clk, .rst_n,
        .result_valid, .result,
        .araddr, .arvalid, .arready,
        .rdata, .rresp, .rvalid, .rready
    );

endmodule

`default_nettype wire

// ==== invsqrt_properties.sv ====
// Concurrent checks on the AXI4-Lite handshakes, the lane latency and
// the ready signals during reset, bound into the accelerator top level.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_properties #(
    parameter int NUM_LANES = 4
) (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  awready,
    input  logic                  wready,
    input  logic                  arready,
    input  logic                  bvalid,
    input  logic                  bready,
    input  logic                  rvalid,
    input  logic                  rready,
    input  logic [NUM_LANES-1:0]  launch,
    input  logic [NUM_LANES-1:0]  result_valid
);

    localparam int LAT = invsqrt_pkg::LANE_LATENCY;

    logic any_failed = 1'b0;    // Sticky, set by any failing property.

    ////////////////////
    // Handshakes.
    b_hold: assert property (@(posedge clk) disable iff (!rst_n)
        bvalid && !bready |=> bvalid)
        else begin
            any_failed = 1'b1;
            $error("bvalid dropped before bready was seen.");
        end

    r_hold: assert property (@(posedge clk) disable iff (!rst_n)
        rvalid && !rready |=> rvalid)
        else begin
            any_failed = 1'b1;
            $error("rvalid dropped before rready was seen.");
        end

    // Each launch comes back on the same lane exactly LAT cycles later.
    lane_latency: assert property (@(posedge clk) disable iff (!rst_n)
        (result_valid | $past(launch, LAT)) != '0 |-> result_valid == $past(launch, LAT))
        else begin
            any_failed = 1'b1;
            $error("result_valid does not match launch %0d cycles earlier.", LAT);
        end

    reset_quiet: assert property (@(posedge clk)
        !rst_n |-> !(awready || wready || arready))
        else begin
            any_failed = 1'b1;
            $error("A ready signal is high during reset.");
        end

endmodule

bind invsqrt_top invsqrt_properties #(.NUM_LANES(NUM_LANES)) u_props (
    .clk, .rst_n,
    .awready, .wready, .arready,
    .bvalid, .bready, .rvalid, .rready,
    .launch, .result_valid
);

`default_nettype wire

// ==== invsqrt_tb.sv ====
// Inverse square root accelerator testbench.
// Clock and reset, AXI4-Lite driver tasks, directed tests and a watchdog.
`timescale 1ns/10ps
`default_nettype none

module invsqrt_tb;

    localparam int          NUM_LANES = 4;
    localparam int          MAX_POLLS = 20;
    localparam int          OP_BUDGET = 200;                    // Cycles per bus operation.
    localparam real         REL_TOL   = 1.0 / 1099511627776.0;  // 2^-40.
    localparam logic [63:0] QNAN      = 64'h7FF8_0000_0000_0001;
    localparam logic [63:0] POS_INF   = 64'h7FF0_0000_0000_0000;
    localparam logic [63:0] POS_ZERO  = 64'h0;

    logic               clk = 1'b0;
    logic               rst_n;
    invsqrt_pkg::addr_t awaddr;
    logic               awvalid;
    logic               awready;
    invsqrt_pkg::word_t wdata;
    logic               wvalid;
    logic               wready;
    logic [1:0]         bresp;
    logic               bvalid;
    logic               bready;
    invsqrt_pkg::addr_t araddr;
    logic               arvalid;
    logic               arready;
    invsqrt_pkg::word_t rdata;
    logic [1:0]         rresp;
    logic               rvalid;
    logic               rready;
    int                 ops_issued = 0;
    int                 cycles     = 0;
    string              test_name  = "reset";

    invsqrt_top #(.NUM_LANES(NUM_LANES)) UUT (
        .clk     (clk),
        .rst_n   (rst_n),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready)
    );

    always #4 clk = ~clk;   // 8 ns period.

    ////////////////////
    // Checks and bus tasks.
    task automatic tick();
        @(posedge clk);
        #1;                 // Drive point after the edge.
    endtask

    task automatic check_value(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else begin
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, expected, actual);
            $display("TEST FAIL");
            $fatal(1, "Value mismatch.");
        end
    endtask

    task automatic check_close(input string what, input real expected,
                               input invsqrt_pkg::fp64_t actual);
        real err;
        err = ($bitstoreal(actual) - expected) / expected;
        if (err < 0.0) err = -err;
        assert (err < REL_TOL) else begin
            $display("FAILED %s %s: expected %h, actual %h, relative error %g",
                     test_name, what, $realtobits(expected), actual, err);
            $display("TEST FAIL");
            $fatal(1, "Result outside tolerance.");
        end
    endtask

    function automatic invsqrt_pkg::addr_t lane_addr(input int lane, input int offset);
        return invsqrt_pkg::addr_t'(lane * invsqrt_pkg::LANE_STRIDE + offset);
    endfunction

    task automatic axi_write(input invsqrt_pkg::addr_t addr, input invsqrt_pkg::word_t data,
                             input logic [1:0] exp_resp);
        logic       taken;
        logic [1:0] resp;
        ops_issued++;
        awaddr  = addr;
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            #1;
            taken = awready && wready;
            tick();
        end
        awvalid = 1'b0;
        wvalid  = 1'b0;
        while (!bvalid) tick();
        resp = bresp;
        tick();             // Response held back for one cycle.
        bready = 1'b1;
        tick();
        bready = 1'b0;
        check_value($sformatf("bresp at %h", addr), 64'(exp_resp), 64'(resp));
    endtask

    task automatic axi_read(input invsqrt_pkg::addr_t addr, output invsqrt_pkg::word_t data);
        logic taken;
        ops_issued++;
        araddr  = addr;
        arvalid = 1'b1;
        taken   = 1'b0;
        while (!taken) begin
            #1;
            taken = arready;
            tick();
        end
        arvalid = 1'b0;
        while (!rvalid) tick();
        data = rdata;
        check_value($sformatf("rresp at %h", addr), 64'(invsqrt_pkg::RESP_OKAY), 64'(rresp));
        tick();             // Read data held back for one cycle.
        rready = 1'b1;
        tick();
        rready = 1'b0;
    endtask

    ////////////////////
    // Lane operations.
    task automatic launch_operand(input int lane, input invsqrt_pkg::fp64_t x);
        axi_write(lane_addr(lane, 0), x[31:0], invsqrt_pkg::RESP_OKAY);
        axi_write(lane_addr(lane, 4), x[63:32], invsqrt_pkg::RESP_OKAY);  // Launches.
    endtask

    task automatic wait_done(input int lane);
        invsqrt_pkg::word_t status;
        int                 polls;
        status = '0;
        polls  = 0;
        while (((status >> lane) & 32'd1) == 32'd0 && polls < MAX_POLLS) begin
            axi_read(invsqrt_pkg::STATUS_ADDR, status);
            polls++;
        end
        assert (((status >> lane) & 32'd1) != 32'd0) else begin
            $display("Lane %0d never reported done within %0d status reads in test %s.",
                     lane, MAX_POLLS, test_name);
            $display("TEST FAIL");
            $fatal(1, "Lane did not finish.");
        end
    endtask

    task automatic read_result(input int lane, output invsqrt_pkg::fp64_t r);
        invsqrt_pkg::word_t lo;
        invsqrt_pkg::word_t hi;
        axi_read(lane_addr(lane, 8), lo);
        axi_read(lane_addr(lane, 12), hi);     // Clears the done bit.
        r = {hi, lo};
    endtask

    task automatic run_operand(input int lane, input invsqrt_pkg::fp64_t x,
                               output invsqrt_pkg::fp64_t r);
        launch_operand(lane, x);
        wait_done(lane);
        read_result(lane, r);
    endtask

    ////////////////////
    // Directed tests.
    task automatic test_reset();
        invsqrt_pkg::word_t w;
        test_name = "reset";
        axi_read(invsqrt_pkg::STATUS_ADDR, w);
        check_value("status", 64'h0, 64'(w));
        for (int i = 0; i < NUM_LANES; i++) begin
            axi_read(lane_addr(i, 8), w);
            check_value($sformatf("lane %0d result low", i), 64'h0, 64'(w));
            axi_read(lane_addr(i, 12), w);
            check_value($sformatf("lane %0d result high", i), 64'h0, 64'(w));
        end
    endtask

    task automatic test_specials();
        invsqrt_pkg::fp64_t ops  [8];
        invsqrt_pkg::fp64_t want [8];
        invsqrt_pkg::fp64_t r;
        test_name = "special_cases";
        ops  = '{64'h7FF8_0000_0000_0000, 64'h7FF0_0000_0000_0001, 64'hC000_0000_0000_0000,
                 64'hFFF0_0000_0000_0000, 64'h7FF0_0000_0000_0000, 64'h0000_0000_0000_0000,
                 64'h8000_0000_0000_0000, 64'h0000_0000_0000_0123};
        want = '{QNAN, QNAN, QNAN, QNAN, POS_ZERO, POS_INF, POS_INF, POS_INF};
        for (int lane = 0; lane < NUM_LANES; lane++) begin
            for (int c = 0; c < 8; c++) begin
                run_operand(lane, ops[c], r);
                check_value($sformatf("lane %0d x=%h", lane, ops[c]), want[c], r);
            end
        end
    endtask

    task automatic test_powers();
        int                 ks [8];
        invsqrt_pkg::fp64_t x;
        invsqrt_pkg::fp64_t want;
        invsqrt_pkg::fp64_t r;
        test_name = "powers_of_four";
        ks = '{-100, -37, -1, 0, 1, 5, 64, 100};
        for (int i = 0; i < 8; i++) begin
            x    = {1'b0, 11'(1023 + 2 * ks[i]), 52'd0};  // 4^k.
            want = {1'b0, 11'(1023 - ks[i]), 52'd0};      // 2^-k.
            run_operand(i % NUM_LANES, x, r);
            check_value($sformatf("4^%0d", ks[i]), want, r);
        end
    endtask

    task automatic test_random();
        invsqrt_pkg::exp_t  e;
        invsqrt_pkg::word_t hi;
        invsqrt_pkg::word_t lo;
        invsqrt_pkg::fp64_t x;
        invsqrt_pkg::fp64_t r;
        test_name = "random_accuracy";
        for (int i = 0; i < 40; i++) begin
            e  = 11'(523 + ($urandom % 1000));     // Unbiased -500 to 499.
            hi = $urandom;
            lo = $urandom;
            x  = {1'b0, e, hi[19:0], lo};
            run_operand(i % NUM_LANES, x, r);
            check_close($sformatf("x=%h", x), 1.0 / $sqrt($bitstoreal(x)), r);
        end
    endtask

    task automatic test_concurrency();
        invsqrt_pkg::fp64_t x    [NUM_LANES];
        invsqrt_pkg::fp64_t want [NUM_LANES];
        invsqrt_pkg::fp64_t r;
        invsqrt_pkg::word_t w;
        test_name = "concurrency";
        for (int i = 0; i < NUM_LANES; i++) begin
            x[i]    = {1'b0, 11'(1025 + 2 * i), 52'd0};  // 4^(i+1).
            want[i] = {1'b0, 11'(1022 - i), 52'd0};
        end
        for (int i = 0; i < NUM_LANES; i++) launch_operand(i, x[i]);
        for (int i = 0; i < NUM_LANES; i++) wait_done(i);
        axi_read(invsqrt_pkg::STATUS_ADDR, w);
        check_value("status all done", 64'hF, 64'(w));
        read_result(2, r);
        check_value("lane 2 result", want[2], r);
        axi_read(invsqrt_pkg::STATUS_ADDR, w);
        check_value("status after lane 2 read", 64'hB, 64'(w));
        for (int i = 0; i < NUM_LANES; i++) begin
            if (i != 2) begin
                read_result(i, r);
                check_value($sformatf("lane %0d result", i), want[i], r);
            end
        end
        axi_read(invsqrt_pkg::STATUS_ADDR, w);
        check_value("status after all reads", 64'h0, 64'(w));
        // Relaunch lane 1 with 4^10.
        launch_operand(1, {1'b0, 11'd1043, 52'd0});
        wait_done(1);
        axi_read(invsqrt_pkg::STATUS_ADDR, w);
        check_value("status after relaunch", 64'h2, 64'(w));
        read_result(1, r);
        check_value("lane 1 relaunch", {1'b0, 11'd1013, 52'd0}, r);
    endtask

    task automatic test_addr_errors();
        invsqrt_pkg::fp64_t r;
        invsqrt_pkg::word_t w;
        test_name = "address_errors";
        axi_write(8'h1C, 32'hDEAD_BEEF, invsqrt_pkg::RESP_SLVERR);
        axi_write(8'h18, 32'h1234_5678, invsqrt_pkg::RESP_SLVERR);
        axi_write(8'h44, 32'h4010_0000, invsqrt_pkg::RESP_SLVERR);    // Lane 4 is absent.
        axi_write(8'h80, 32'h0000_0001, invsqrt_pkg::RESP_SLVERR);
        axi_write(invsqrt_pkg::STATUS_ADDR, 32'hF, invsqrt_pkg::RESP_SLVERR);
        read_result(1, r);
        check_value("lane 1 result kept", {1'b0, 11'd1013, 52'd0}, r);
        axi_read(invsqrt_pkg::STATUS_ADDR, w);
        check_value("status unchanged", 64'h0, 64'(w));
        axi_read(8'h80, w);
        check_value("read 80", 64'h0, 64'(w));
        axi_read(8'h44, w);
        check_value("read 44", 64'h0, 64'(w));
        axi_read(8'hF4, w);
        check_value("read F4", 64'h0, 64'(w));
    endtask

    ////////////////////
    // Watchdog and main sequence.
    initial begin : watchdog
        while (cycles <= OP_BUDGET * (ops_issued + 1)) begin
            @(posedge clk);
            cycles++;
        end
        $display("Watchdog timeout after %0d cycles with %0d bus operations issued.",
                 cycles, ops_issued);
        $display("TEST FAIL");
        $fatal(1, "Simulation stalled.");
    end

    initial begin
        void'($urandom(32'hd60e_e5d2));
        rst_n   = 1'b0;
        awaddr  = '0;
        awvalid = 1'b0;
        wdata   = '0;
        wvalid  = 1'b0;
        bready  = 1'b0;
        araddr  = '0;
        arvalid = 1'b0;
        rready  = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
        test_reset();
        test_specials();
        test_powers();
        test_random();
        test_concurrency();
        test_addr_errors();
        if (UUT.u_props.any_failed == 1'b0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            $display("TEST FAIL");
            $fatal(1, "A bound property failed.");
        end
    end

endmodule

`default_nettype wire

// ==== build.f ====
invsqrt_pkg.sv
invsqrt_seed_rom.sv
invsqrt_nr_stage.sv
invsqrt_lane.sv
invsqrt_dispatch.sv
invsqrt_collect.sv
invsqrt_top.sv
invsqrt_properties.sv
invsqrt_tb.sv

// ==== Makefile ====
sim:
	verilator --binary --timing --assert --top-module invsqrt_tb -f build.f
	./obj_dir/Vinvsqrt_tb | tee sim.log
	grep -q "^TEST PASS$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: sim clean
